/* verification/dcache_cases.txt */
# op (0 load, 1 store), size (0 byte, 1 half, 2 word), addr, wdata, tlb_hit, bypass_found
# then expected memory reads, memory writes and writeback line address, all hex
0 0 00008083 00000000 1 0 1 0 00000000
0 1 00008096 00000000 1 0 1 0 00000000
0 2 00009088 00000000 1 0 1 0 00000000
1 0 00008081 000000a5 1 0 0 0 00000000
1 1 0000908a 0000beef 1 0 0 0 00000000
1 2 0000809c deadbeef 1 0 0 0 00000000
1 0 00009095 00000080 1 0 1 0 00000000
0 0 00008081 00000000 1 0 0 0 00000000
0 1 0000908a 00000000 1 0 0 0 00000000
0 2 00008080 00000000 1 0 0 0 00000000
0 2 0000a084 00000000 1 0 1 1 00009080
0 0 00008082 00000000 1 0 0 0 00000000
0 1 0000908a 00000000 1 0 1 0 00000000
1 2 00009080 11111111 0 0 0 0 00000000
0 2 00009080 00000000 1 1 0 0 00000000
0 2 00009080 00000000 1 0 0 0 00000000
1 1 0000b092 00007f80 1 0 1 1 00008090
1 2 00008098 cafef00d 1 0 1 1 00009090
0 0 00009095 00000000 1 0 1 1 0000b090
0 1 0000b092 00000000 1 0 1 1 00008090

/* project.f */
logic/cpu_access_pkg.sv
logic/cache_geometry_pkg.sv
logic/way_store.sv
logic/tag_directory.sv
logic/line_store.sv
logic/miss_controller.sv
logic/dcache_top.sv
verification/dcache_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = dcache_tb
FILELIST = project.f
LOG      = sim.log
PASS     = Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS)" $(LOG)

lint:
	$(TOOL) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

/* verification/dcache_tb.sv */
module dcache_tb
    import cpu_access_pkg::*;
    import cache_geometry_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 64;

    typedef struct packed {
        logic        store;
        logic [2:0]  size;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        tlb_hit;
        logic        bypass;
        logic [3:0]  exp_reads;
        logic [3:0]  exp_writes;
        logic [31:0] wb_addr;
    } test_case_t;

    logic      clk;
    logic      reset;
    cpu_req_t  req;
    cpu_resp_t resp;
    mem_req_t  mem_req;
    line_t     mem_rdata;
    logic      mem_ready;

    // Byte view of what the CPU has stored so far
    logic [7:0]  ref_mem [logic [31:0]];
    logic [31:0] mem_words [logic [31:0]];
    logic [31:0] lcg_state;
    logic [31:0] rd_addr;
    logic [31:0] wr_addr;
    logic        wr_after_rd;
    logic        timed_out;
    int          rd_count;
    int          wr_count;
    int          errors;
    int          failed;

    dcache_top #(
        .NUM_SETS (2)
    ) DUT (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .resp      (resp),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Untouched words hold their own address with a marker folded in
    function automatic logic [31:0] initial_word(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ 32'h5a5a_0000;
    endfunction

    function automatic logic [7:0] ref_byte(input logic [31:0] addr);
        logic [31:0] word;
        if (ref_mem.exists(addr)) begin
            return ref_mem[addr];
        end
        word = initial_word(addr) >> {addr[1:0], 3'b000};
        return word[7:0];
    endfunction

    function automatic logic [31:0] ref_word(input logic [31:0] addr);
        return {ref_byte(addr + 32'd3), ref_byte(addr + 32'd2),
                ref_byte(addr + 32'd1), ref_byte(addr)};
    endfunction

    function automatic logic [31:0] expected_load(input logic [31:0] addr,
                                                  input logic [2:0] size);
        logic [31:0] word;
        word = ref_word(addr);
        case (size)
            3'd0:    return {{24{word[7]}}, word[7:0]};
            3'd1:    return {{16{word[15]}}, word[15:0]};
            default: return word;
        endcase
    endfunction

    function automatic void apply_store(input logic [31:0] addr, input logic [2:0] size,
                                        input logic [31:0] data);
        int nbytes;
        nbytes = (size == 3'd0) ? 1 : ((size == 3'd1) ? 2 : 4);
        for (int i = 0; i < nbytes; i++) begin
            ref_mem[addr + 32'(i)] = data[8*i +: 8];
        end
    endfunction

    function automatic logic [31:0] read_memory(input logic [31:0] addr);
        return mem_words.exists(addr) ? mem_words[addr] : initial_word(addr);
    endfunction

    // Logs one exchange and pulses ready after 1 to 4 cycles
    task automatic serve_memory();
        logic [31:0] base;
        logic [31:0] delay;
        logic [31:0] word;
        base  = mem_req.addr;
        delay = 32'd1 + (next_rand() >> 30);
        if (mem_req.write) begin
            wr_count++;
            wr_addr = base;
            if (rd_count != 0) begin
                wr_after_rd = 1'b1;
            end
            for (int i = 0; i < 4; i++) begin
                word = mem_req.wdata[32*i +: 32];
                assert (word == ref_word(base + 32'(4*i))) else begin
                    $display("** Error at %0t: writeback word %h is %h, expected %h",
                             $time, base + 32'(4*i), word, ref_word(base + 32'(4*i)));
                    errors++;
                end
                mem_words[base + 32'(4*i)] = word;
            end
        end else begin
            rd_count++;
            rd_addr = base;
        end
        repeat (delay) @(posedge clk);
        #1;
        mem_ready = 1'b1;
        for (int i = 0; i < 4; i++) begin
            mem_rdata[32*i +: 32] = read_memory(base + 32'(4*i));
        end
        @(posedge clk);
        #1;
        mem_ready = 1'b0;
    endtask

    always begin
        @(negedge clk);
        if (!reset && (mem_req.read || mem_req.write)) begin
            serve_memory();
        end
    end

    task automatic run_case(input int num, input test_case_t tc);
        logic        active;
        logic        saw_busy;
        logic        hit;
        logic [31:0] rdata;
        logic [31:0] expected;
        int          errors_before;
        int          cycles;
        active        = tc.tlb_hit && (tc.store || !tc.bypass);
        expected      = expected_load(tc.addr, tc.size);
        errors_before = errors;
        saw_busy      = 1'b0;
        cycles        = 0;
        @(posedge clk);
        #1;
        rd_count         = 0;
        wr_count         = 0;
        wr_after_rd      = 1'b0;
        req.read         = !tc.store;
        req.write        = tc.store;
        req.tlb_hit      = tc.tlb_hit;
        req.bypass_found = tc.bypass;
        req.size         = access_size_t'(tc.size);
        req.addr         = tc.addr;
        req.wdata        = tc.wdata;
        @(negedge clk);
        while (resp.busy && cycles < TIMEOUT_CYCLES) begin
            saw_busy = 1'b1;
            cycles++;
            @(negedge clk);
        end
        if (resp.busy) begin
            $display("Test %0d timed out because busy stayed high for %0d cycles", num, cycles);
            errors++;
            failed++;
            timed_out = 1'b1;
            req = '0;
            return;
        end
        hit   = resp.hit;
        rdata = resp.rdata;
        @(posedge clk);
        #1;
        req = '0;
        @(negedge clk);
        assert (saw_busy == (tc.exp_reads != 4'd0) && hit == active) else begin
            $display("** Error at %0t: busy seen %b, hit %b, expected miss %b active %b",
                     $time, saw_busy, hit, tc.exp_reads != 4'd0, active);
            errors++;
        end
        assert (tc.store || !active || rdata == expected) else begin
            $display("** Error at %0t: load %h returned %h, expected %h",
                     $time, tc.addr, rdata, expected);
            errors++;
        end
        assert (resp.ack == (active && tc.store)) else begin
            $display("** Error at %0t: ack is %b after the access", $time, resp.ack);
            errors++;
        end
        assert (rd_count == int'(tc.exp_reads) && wr_count == int'(tc.exp_writes)) else begin
            $display("** Error at %0t: %0d reads and %0d writes, expected %0d and %0d",
                     $time, rd_count, wr_count, tc.exp_reads, tc.exp_writes);
            errors++;
        end
        assert (rd_count == 0 || rd_addr == {tc.addr[31:4], 4'h0}) else begin
            $display("** Error at %0t: refill read of %h", $time, rd_addr);
            errors++;
        end
        assert (wr_count == 0 || (wr_addr == tc.wb_addr && !wr_after_rd)) else begin
            $display("** Error at %0t: writeback of %h, expected %h before the read",
                     $time, wr_addr, tc.wb_addr);
            errors++;
        end
        if (active && tc.store) begin
            apply_store(tc.addr, tc.size, tc.wdata);
        end
        if (errors != errors_before) begin
            failed++;
        end
        $display("Test %0d %s %h: %s", num, tc.store ? "store" : "load", tc.addr,
                 (errors == errors_before) ? "ok" : "FAILED");
    endtask

    initial begin
        int          fd;
        int          count;
        int          num;
        string       text;
        logic [31:0] f [9];
        test_case_t  tc;
        req         = '0;
        reset       = 1'b1;
        mem_ready   = 1'b0;
        mem_rdata   = '0;
        lcg_state   = 32'h4b18_fe35;
        timed_out   = 1'b0;
        wr_after_rd = 1'b0;
        errors      = 0;
        failed      = 0;
        num         = 0;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        assert (!resp.busy && !resp.ack && !mem_req.read && !mem_req.write) else begin
            $display("** Error at %0t: outputs not idle after reset", $time);
            errors++;
        end
        fd = $fopen("verification/dcache_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open verification/dcache_cases.txt");
            errors++;
        end else begin
            while (!$feof(fd) && !timed_out) begin
                count = $fgets(text, fd);
                if (count > 0 && text.len() > 1 && text[0] != "#") begin
                    count = $sscanf(text, "%h %h %h %h %h %h %h %h %h",
                                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
                    if (count == 9) begin
                        tc.store      = f[0][0];
                        tc.size       = f[1][2:0];
                        tc.addr       = f[2];
                        tc.wdata      = f[3];
                        tc.tlb_hit    = f[4][0];
                        tc.bypass     = f[5][0];
                        tc.exp_reads  = f[6][3:0];
                        tc.exp_writes = f[7][3:0];
                        tc.wb_addr    = f[8];
                        num++;
                        run_case(num, tc);
                    end
                end
            end
            $fclose(fd);
        end
        if (num == 0) begin
            $display("No test cases were read");
            errors++;
        end
        $display("Tests run: %0d, failed: %0d, errors: %0d", num, failed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* logic/dcache_top.sv */
module dcache_top
    import cpu_access_pkg::*;
    import cache_geometry_pkg::*;
#(
    parameter int NUM_SETS = 2
) (
    input  logic      clk,
    input  logic      reset,
    input  cpu_req_t  req,
    output cpu_resp_t resp,
    output mem_req_t  mem_req,
    input  line_t     mem_rdata,
    input  logic      mem_ready
);

    logic        hit;
    logic        hit_way;
    logic        victim_way;
    tag_entry_t  victim_entry;
    logic [31:0] load_data;
    line_t       victim_line;
    logic        store_en;
    logic        fill_en;
    logic        fill_way;
    line_t       fill_line;

    tag_directory #(
        .NUM_SETS (NUM_SETS)
    ) u_tag_directory (
        .clk          (clk),
        .reset        (reset),
        .req          (req),
        .store_en     (store_en),
        .fill_en      (fill_en),
        .fill_way     (fill_way),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_entry (victim_entry)
    );

    // Line store follows the controller's write way for victim and refill
    line_store #(
        .NUM_SETS (NUM_SETS)
    ) u_line_store (
        .clk         (clk),
        .reset       (reset),
        .req         (req),
        .hit_way     (hit_way),
        .victim_way  (fill_way),
        .store_en    (store_en),
        .fill_en     (fill_en),
        .fill_line   (fill_line),
        .load_data   (load_data),
        .victim_line (victim_line)
    );

    miss_controller u_miss_controller (
        .clk          (clk),
        .reset        (reset),
        .req          (req),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_entry (victim_entry),
        .load_data    (load_data),
        .victim_line  (victim_line),
        .mem_rdata    (mem_rdata),
        .mem_ready    (mem_ready),
        .resp         (resp),
        .mem_req      (mem_req),
        .store_en     (store_en),
        .fill_en      (fill_en),
        .fill_way     (fill_way),
        .fill_line    (fill_line)
    );

endmodule

/* logic/miss_controller.sv */
module miss_controller
    import cpu_access_pkg::*;
    import cache_geometry_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  cpu_req_t    req,
    input  logic        hit,
    input  logic        hit_way,
    input  logic        victim_way,
    input  tag_entry_t  victim_entry,
    input  logic [31:0] load_data,
    input  line_t       victim_line,
    input  line_t       mem_rdata,
    input  logic        mem_ready,
    output cpu_resp_t   resp,
    output mem_req_t    mem_req,
    output logic        store_en,
    output logic        fill_en,
    output logic        fill_way,
    output line_t       fill_line
);

    typedef enum logic [1:0] {
        IDLE,
        WRITEBACK,
        REFILL
    } state_t;

    state_t state;
    state_t state_next;
    logic   victim_q;
    logic   ack_q;
    logic   active;
    logic   miss;

    // tlb misses and bypassed loads never reach the arrays
    assign active = req.tlb_hit && (req.write || (req.read && !req.bypass_found));
    assign miss   = active && !hit;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (miss) begin
                    if (victim_entry.valid && victim_entry.dirty) begin
                        state_next = WRITEBACK;
                    end else begin
                        state_next = REFILL;
                    end
                end
            end
            WRITEBACK: if (mem_ready) state_next = REFILL;
            REFILL:    if (mem_ready) state_next = IDLE;
            default:   state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            ack_q <= 1'b0;
        end else begin
            state <= state_next;
            ack_q <= store_en;
        end
    end

    // Victim stays fixed for the whole miss
    always_ff @(posedge clk) begin
        if (state == IDLE && miss) begin
            victim_q <= victim_way;
        end
    end

    assign store_en  = (state == IDLE) && active && req.write && hit;
    assign fill_en   = (state == REFILL) && mem_ready;
    assign fill_line = mem_rdata;

    // Latched victim while a miss is in progress
    assign fill_way = (state != IDLE) ? victim_q : (hit ? hit_way : victim_way);

    always_comb begin
        mem_req = '0;
        case (state)
            WRITEBACK: begin
                mem_req.write = 1'b1;
                mem_req.addr  = {victim_entry.line_addr, {OFFSET_BITS{1'b0}}};
                mem_req.wdata = victim_line;
            end
            REFILL: begin
                mem_req.read = 1'b1;
                mem_req.addr = {req.addr[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
            end
            default: ;
        endcase
    end

    always_comb begin
        resp.hit   = active && hit && (state == IDLE);
        resp.busy  = miss || (state != IDLE);
        resp.ack   = ack_q;
        resp.rdata = (resp.hit && req.read) ? load_data : 32'h0;
    end

endmodule

/* logic/line_store.sv */
module line_store
    import cpu_access_pkg::*;
    import cache_geometry_pkg::*;
#(
    parameter int NUM_SETS = 2
) (
    input  logic        clk,
    input  logic        reset,
    input  cpu_req_t    req,
    input  logic        hit_way,
    input  logic        victim_way,
    input  logic        store_en,
    input  logic        fill_en,
    input  line_t       fill_line,
    output logic [31:0] load_data,
    output line_t       victim_line
);

    localparam int SET_BITS = $clog2(NUM_SETS);

    logic [SET_BITS-1:0] set;
    line_t               lines [NUM_WAYS];
    line_t               hit_line;
    line_t               merged_line;
    logic [31:0]         hit_word;
    logic [31:0]         merged_word;
    logic [1:0]          word_sel;
    logic [1:0]          byte_sel;

    assign set = req.addr[OFFSET_BITS +: SET_BITS];

    way_store #(
        .entry_t  (line_t),
        .NUM_SETS (NUM_SETS)
    ) u_lines (
        .clk        (clk),
        .reset      (reset),
        .set        (set),
        .rd_entries (lines),
        .wr_en      (store_en || fill_en),
        .wr_way     (fill_en ? victim_way : hit_way),
        .wr_entry   (fill_en ? fill_line : merged_line)
    );

    always_comb begin
        word_sel  = word_offset(req.addr);
        byte_sel  = byte_offset(req.addr);
        hit_line  = lines[hit_way];
        hit_word  = hit_line[32*word_sel +: 32];
        load_data = sign_extend_load(hit_word >> (8 * byte_sel), req.size);

        // Halfwords are assumed aligned
        merged_word = hit_word;
        case (req.size)
            size_byte: merged_word[8*byte_sel +: 8]      = req.wdata[7:0];
            size_half: merged_word[16*byte_sel[1] +: 16] = req.wdata[15:0];
            default:   merged_word                       = req.wdata;
        endcase
        merged_line                      = hit_line;
        merged_line[32*word_sel +: 32]   = merged_word;
    end

    assign victim_line = lines[victim_way];

endmodule

/* logic/tag_directory.sv */
module tag_directory
    import cpu_access_pkg::*;
    import cache_geometry_pkg::*;
#(
    parameter int NUM_SETS = 2
) (
    input  logic       clk,
    input  logic       reset,
    input  cpu_req_t   req,
    input  logic       store_en,
    input  logic       fill_en,
    input  logic       fill_way,
    output logic       hit,
    output logic       hit_way,
    output logic       victim_way,
    output tag_entry_t victim_entry
);

    localparam int SET_BITS = $clog2(NUM_SETS);

    logic [SET_BITS-1:0] set;
    line_addr_t          req_line;
    tag_entry_t          entries [NUM_WAYS];
    tag_entry_t          wr_entry;
    logic [NUM_WAYS-1:0] match;
    logic [NUM_SETS-1:0] lru;
    logic                touch;

    assign set      = req.addr[OFFSET_BITS +: SET_BITS];
    assign req_line = req.addr[31:OFFSET_BITS];

    way_store #(
        .entry_t  (tag_entry_t),
        .NUM_SETS (NUM_SETS)
    ) u_tags (
        .clk        (clk),
        .reset      (reset),
        .set        (set),
        .rd_entries (entries),
        .wr_en      (fill_en || store_en),
        .wr_way     (fill_en ? fill_way : hit_way),
        .wr_entry   (wr_entry)
    );

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            match[w] = entries[w].valid && (entries[w].line_addr == req_line);
        end
    end

    assign hit     = |match;
    assign hit_way = match[1];

    // Empty ways are used up before LRU picks a victim
    always_comb begin
        if (!entries[0].valid) begin
            victim_way = 1'b0;
        end else if (!entries[1].valid) begin
            victim_way = 1'b1;
        end else begin
            victim_way = lru[set];
        end
    end

    assign victim_entry = entries[victim_way];

    // Refill lands clean and the replayed store marks it dirty
    always_comb begin
        if (fill_en) begin
            wr_entry = '{valid: 1'b1, dirty: 1'b0, line_addr: req_line};
        end else begin
            wr_entry       = entries[hit_way];
            wr_entry.dirty = 1'b1;
        end
    end

    assign touch = hit && req.tlb_hit && ((req.read && !req.bypass_found) || store_en);

    always_ff @(posedge clk) begin
        if (reset) begin
            lru <= '0;
        end else if (fill_en) begin
            lru[set] <= ~fill_way;
        end else if (touch) begin
            lru[set] <= ~hit_way;
        end
    end

endmodule

/* logic/way_store.sv */
module way_store
    import cache_geometry_pkg::*;
#(
    parameter type entry_t  = logic [31:0],
    parameter int  NUM_SETS = 2
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [$clog2(NUM_SETS)-1:0] set,
    output entry_t                      rd_entries [NUM_WAYS],
    input  logic                        wr_en,
    input  logic                        wr_way,
    input  entry_t                      wr_entry
);

    entry_t mem [NUM_SETS][NUM_WAYS];

    // Both ways of the addressed set are visible at once
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            rd_entries[w] = mem[set][w];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                for (int w = 0; w < NUM_WAYS; w++) begin
                    mem[s][w] <= '0;
                end
            end
        end else if (wr_en) begin
            mem[set][wr_way] <= wr_entry;
        end
    end

endmodule

/* logic/cache_geometry_pkg.sv */
package cache_geometry_pkg;

    // Single LRU bit per set only works for two ways
    localparam int NUM_WAYS    = 2;
    localparam int LINE_BITS   = 128;
    localparam int OFFSET_BITS = 4;

    typedef logic [LINE_BITS-1:0] line_t;

    // Full address above the line offset, set bits included
    typedef logic [31-OFFSET_BITS:0] line_addr_t;

    typedef struct packed {
        logic       valid;
        logic       dirty;
        line_addr_t line_addr;
    } tag_entry_t;

    typedef struct packed {
        logic        read;
        logic        write;
        logic [31:0] addr;
        line_t       wdata;
    } mem_req_t;

    // Word within the line
    function automatic logic [1:0] word_offset(input logic [31:0] addr);
        return addr[3:2];
    endfunction

    // Byte within the word
    function automatic logic [1:0] byte_offset(input logic [31:0] addr);
        return addr[1:0];
    endfunction

endpackage

/* logic/cpu_access_pkg.sv */
package cpu_access_pkg;

    // funct3 size codes shared by loads and stores
    typedef enum logic [2:0] {
        size_byte = 3'b000,
        size_half = 3'b001,
        size_word = 3'b010
    } access_size_t;

    typedef struct packed {
        logic         read;
        logic         write;
        logic         tlb_hit;
        logic         bypass_found;
        access_size_t size;
        logic [31:0]  addr;
        logic [31:0]  wdata;
    } cpu_req_t;

    typedef struct packed {
        logic        hit;
        logic        busy;
        logic        ack;
        logic [31:0] rdata;
    } cpu_resp_t;

    // Expects the addressed bytes already shifted down to bit 0
    function automatic logic [31:0] sign_extend_load(input logic [31:0] bytes,
                                                     input access_size_t size);
        case (size)
            size_byte: return {{24{bytes[7]}}, bytes[7:0]};
            size_half: return {{16{bytes[15]}}, bytes[15:0]};
            default:   return bytes;
        endcase
    endfunction

endpackage
